/* src/enemy_consts.svh */
// Sprite geometry, playfield limits and tick constants shared by the enemy RTL and its checker
`ifndef ENEMY_CONSTS_SVH
`define ENEMY_CONSTS_SVH

// Enemy sprite box, one texel per screen pixel
`define ENEMY_W 26
`define ENEMY_H 26

// Player bounding box used by the chase test
`define PLAYER_W 18
`define PLAYER_H 20

// Playfield borders
`define X_MIN 0
`define X_MAX 319
`define Y_MIN 52    // Below the status bar
`define Y_MAX 205

// Start centers are spaced by index, enemy k sits at (k+1) steps
`define X_ORIGIN_STEP 70
`define Y_ORIGIN_STEP 40

// Frame edges per move tick
`define TICK_DIV 4

// Enemies on the field
`define NUM_ENEMIES 3

`endif

/* src/enemy_pkg.sv */
// Types shared by the enemy subsystem: coordinates, sprite addresses, facing and positions
package enemy_pkg;

    // Screen coordinate, covers 0..319 and 0..239
    typedef logic [8:0] coordT;

    // Sprite-ROM address, twelve frames of 26x26 texels
    typedef logic [12:0] spriteAddrT;

    // Walk-step count, four steps per cycle
    typedef logic [1:0] animT;

    // Facing direction, the value picks a group of three frames in the ROM
    typedef enum logic [1:0] {
        DIR_DOWN  = 2'd0,
        DIR_LEFT  = 2'd1,
        DIR_UP    = 2'd2,
        DIR_RIGHT = 2'd3
    } dirT;

    // Top-left corner of a box
    typedef struct packed {
        coordT x;
        coordT y;
    } posT;

endpackage

/* src/frame_tick.sv */
// Turns the slow frame clock into a one-cycle move tick on every TICK_DIV-th rising edge
`timescale 1ns/1ns
`include "enemy_consts.svh"

module frame_tick (
    input  logic Clk,
    input  logic arstN,
    input  logic frameClk,      // Asynchronous to Clk
    output logic moveTick
);

    logic       syncA;
    logic       syncB;
    logic       syncPrev;
    logic       edgePulse;
    logic [1:0] edgeCount;

    // Two-flop synchronizer, then edge detect on the clean copy
    always_ff @(posedge Clk or negedge arstN) begin
        if (!arstN) begin
            syncA     <= 1'b0;
            syncB     <= 1'b0;
            syncPrev  <= 1'b0;
            edgePulse <= 1'b0;
        end else begin
            syncA     <= frameClk;
            syncB     <= syncA;
            syncPrev  <= syncB;
            edgePulse <= syncB & ~syncPrev;
        end
    end

    // Count edges, pass one strobe per group
    always_ff @(posedge Clk or negedge arstN) begin
        if (!arstN) begin
            edgeCount <= '0;
            moveTick  <= 1'b0;
        end else begin
            moveTick <= 1'b0;
            if (edgePulse) begin
                edgeCount <= edgeCount + 2'd1;
                if (edgeCount == 2'(`TICK_DIV - 1)) begin
                    edgeCount <= '0;
                    moveTick  <= 1'b1;   // Fourth edge of the group
                end
            end
        end
    end

endmodule

/* src/walk_anim.sv */
// Walk-step counter of one enemy, steps on each move and drops to the idle frame when standing
`timescale 1ns/1ns

module walk_anim import enemy_pkg::*; (
    input  logic Clk,
    input  logic arstN,
    input  logic stepEn,    // Move tick for a living enemy
    input  logic moving,    // The enemy changes position on this tick
    output animT step
);

    // Step 0 is the idle pose, steps 1 and 3 pick the two stride frames
    always_ff @(posedge Clk or negedge arstN) begin
        if (!arstN) begin
            step <= '0;
        end else if (stepEn) begin
            if (moving) begin
                step <= step + 2'd1;   // Wraps after four steps
            end else begin
                step <= '0;
            end
        end
    end

endmodule

/* src/enemy.sv */
// One enemy: chases the player on move ticks and reports its sprite texel for the scanned pixel
`timescale 1ns/1ns
`include "enemy_consts.svh"

module enemy import enemy_pkg::*; #(
    parameter int enemyId = 0
) (
    input  logic       Clk,
    input  logic       arstN,
    input  logic       moveTick,
    input  logic       alive,
    input  posT        playerPos,
    input  posT        pixel,
    output posT        pos,
    output logic       attackReady,
    output logic       hit,
    output spriteAddrT addr
);

    // Start corner is the index-spaced center minus half the sprite
    localparam coordT startX = coordT'((enemyId + 1) * `X_ORIGIN_STEP - `ENEMY_W / 2);
    localparam coordT startY = coordT'((enemyId + 1) * `Y_ORIGIN_STEP - `ENEMY_H / 2);
    localparam spriteAddrT spriteArea = spriteAddrT'(`ENEMY_W * `ENEMY_H);

    dirT        dir;
    dirT        dirNext;
    posT        posNext;
    logic       moving;
    animT       step;

    // Edges are held one bit wider so sums near the right border do not wrap
    logic [9:0] rightEdge;
    logic [9:0] bottomEdge;
    logic [9:0] playerRight;
    logic [9:0] playerBottom;

    logic       inBox;
    coordT      offX;
    coordT      offY;
    logic [3:0] frameIdx;

    assign rightEdge    = {1'b0, pos.x} + 10'(`ENEMY_W);
    assign bottomEdge   = {1'b0, pos.y} + 10'(`ENEMY_H);
    assign playerRight  = {1'b0, playerPos.x} + 10'(`PLAYER_W);
    assign playerBottom = {1'b0, playerPos.y} + 10'(`PLAYER_H);

    // Chase rule, X is closed first, then Y
    always_comb begin
        posNext = pos;
        dirNext = dir;
        if (rightEdge < {1'b0, playerPos.x}) begin
            dirNext = DIR_RIGHT;
            if (rightEdge < 10'(`X_MAX)) begin
                posNext.x = pos.x + 9'd1;
            end
        end else if ({1'b0, pos.x} > playerRight) begin
            dirNext = DIR_LEFT;
            if (pos.x > coordT'(`X_MIN)) begin
                posNext.x = pos.x - 9'd1;
            end
        end else if (bottomEdge < {1'b0, playerPos.y}) begin
            dirNext = DIR_DOWN;
            if (bottomEdge < 10'(`Y_MAX)) begin
                posNext.y = pos.y + 9'd1;
            end
        end else if ({1'b0, pos.y} > playerBottom) begin
            dirNext = DIR_UP;
            if (pos.y > coordT'(`Y_MIN)) begin
                posNext.y = pos.y - 9'd1;
            end
        end
    end

    assign moving = (posNext != pos);   // False at a border stop or next to the player

    always_ff @(posedge Clk or negedge arstN) begin
        if (!arstN) begin
            pos.x       <= startX;
            pos.y       <= startY;
            dir         <= DIR_DOWN;
            attackReady <= 1'b0;
        end else if (!alive) begin
            attackReady <= 1'b0;          // Dead enemies hold their place
        end else if (moveTick) begin
            pos         <= posNext;
            dir         <= dirNext;
            attackReady <= ~moving;
        end
    end

    walk_anim uWalkAnim (
        .Clk    (Clk),
        .arstN  (arstN),
        .stepEn (moveTick & alive),
        .moving (moving),
        .step   (step)
    );

    // Texel lookup for the scanned pixel
    assign offX  = pixel.x - pos.x;
    assign offY  = pixel.y - pos.y;
    assign inBox = (pixel.x >= pos.x) && ({1'b0, pixel.x} < rightEdge) &&
                   (pixel.y >= pos.y) && ({1'b0, pixel.y} < bottomEdge);
    assign hit   = inBox & alive;

    // Three frames per direction: idle, stride one, stride two
    always_comb begin
        frameIdx = 4'(dir) * 4'd3;
        if (step[0]) begin
            frameIdx = frameIdx + 4'd1 + 4'(step[1]);
        end
    end

    assign addr = hit ? spriteAddrT'(offX) + spriteAddrT'(offY) * spriteAddrT'(`ENEMY_W)
                        + spriteAddrT'(frameIdx) * spriteArea
                      : '0;

endmodule

/* src/enemy_field.sv */
// Top of the enemy subsystem: shared move tick, the enemy array and the sprite priority select
`timescale 1ns/1ns
`include "enemy_consts.svh"

module enemy_field import enemy_pkg::*; (
    input  logic                         Clk,
    input  logic                         arstN,
    input  logic                         frameClk,
    input  logic [`NUM_ENEMIES-1:0]      alive,
    input  posT                          playerPos,
    input  posT                          pixel,
    output posT  [`NUM_ENEMIES-1:0]      enemyPos,
    output logic [`NUM_ENEMIES-1:0]      attackReady,
    output logic                         pixelHit,
    output spriteAddrT                   spriteAddr,
    output logic [1:0]                   hitIndex
);

    logic                         moveTick;
    logic [`NUM_ENEMIES-1:0]      hits;
    spriteAddrT [`NUM_ENEMIES-1:0] addrs;

    // One divider for the whole field keeps all enemies in step
    frame_tick uFrameTick (
        .Clk      (Clk),
        .arstN    (arstN),
        .frameClk (frameClk),
        .moveTick (moveTick)
    );

    for (genvar i = 0; i < `NUM_ENEMIES; i++) begin : gEnemy
        enemy #(
            .enemyId (i)
        ) uEnemy (
            .Clk         (Clk),
            .arstN       (arstN),
            .moveTick    (moveTick),
            .alive       (alive[i]),
            .playerPos   (playerPos),
            .pixel       (pixel),
            .pos         (enemyPos[i]),
            .attackReady (attackReady[i]),
            .hit         (hits[i]),
            .addr        (addrs[i])
        );
    end

    // Walk from the highest index down so the lowest hitting index is left standing
    always_comb begin
        pixelHit   = 1'b0;
        spriteAddr = '0;
        hitIndex   = '0;
        for (int i = `NUM_ENEMIES - 1; i >= 0; i--) begin
            if (hits[i]) begin
                pixelHit   = 1'b1;
                spriteAddr = addrs[i];
                hitIndex   = 2'(i);
            end
        end
    end

endmodule

/* tb/enemy_checker.sv */
// Reference model of enemy motion and sprite addressing that checks the field outputs on request
`timescale 1ns/1ns
`include "enemy_consts.svh"

module enemy_checker import enemy_pkg::*; (
    input  logic                    Clk,
    input  logic                    resetCheck,   // Compare with the start state
    input  logic                    posCheck,     // Compare positions and attack flags
    input  logic                    groupDone,    // Last frame edge completed a group
    input  logic                    pixelCheck,   // Compare the sprite outputs for pixel
    input  logic                    report,       // Print the per-test lines
    input  logic [`NUM_ENEMIES-1:0] alive,
    input  posT                     playerPos,
    input  posT                     pixel,
    input  posT  [`NUM_ENEMIES-1:0] enemyPos,
    input  logic [`NUM_ENEMIES-1:0] attackReady,
    input  logic                    pixelHit,
    input  spriteAddrT              spriteAddr,
    input  logic [1:0]              hitIndex,
    output int                      checks,
    output int                      errors
);

    localparam int numTests = 5;

    string testName [numTests] = '{"reset", "chase", "attack", "sprite", "divider"};
    int    testChecks [numTests] = '{default: 0};
    int    testErrors [numTests] = '{default: 0};
    int    checkCount = 0;
    int    errorCount = 0;

    // Model state per enemy
    int  mx [`NUM_ENEMIES];
    int  my [`NUM_ENEMIES];
    dirT mDir [`NUM_ENEMIES];
    int  mStep [`NUM_ENEMIES];
    bit  mAttack [`NUM_ENEMIES];

    assign checks = checkCount;
    assign errors = errorCount;

    task automatic compare(input int t, input string what, input int expected, input int actual);
        checkCount++;
        testChecks[t]++;
        if (expected != actual) begin
            errorCount++;
            testErrors[t]++;
            $display("[FAIL] %s %s: expected %0d, actual %0d", testName[t], what, expected, actual);
        end
    endtask

    // One chase step, X closes first and each border stops the step but not the turn
    task automatic stepModel(input int k);
        int px;
        int py;
        int oldX;
        int oldY;
        bit moved;
        px   = int'(playerPos.x);
        py   = int'(playerPos.y);
        oldX = mx[k];
        oldY = my[k];
        if (mx[k] + `ENEMY_W < px) begin
            mDir[k] = DIR_RIGHT;
            mx[k] = (mx[k] + `ENEMY_W < `X_MAX) ? mx[k] + 1 : mx[k];
        end else if (mx[k] > px + `PLAYER_W) begin
            mDir[k] = DIR_LEFT;
            mx[k] = (mx[k] > `X_MIN) ? mx[k] - 1 : mx[k];
        end else if (my[k] + `ENEMY_H < py) begin
            mDir[k] = DIR_DOWN;
            my[k] = (my[k] + `ENEMY_H < `Y_MAX) ? my[k] + 1 : my[k];
        end else if (my[k] > py + `PLAYER_H) begin
            mDir[k] = DIR_UP;
            my[k] = (my[k] > `Y_MIN) ? my[k] - 1 : my[k];
        end
        moved      = (mx[k] != oldX) || (my[k] != oldY);
        mAttack[k] = !moved;
        mStep[k]   = moved ? (mStep[k] + 1) % 4 : 0;   // Standing shows the idle frame
    endtask

    task automatic checkPixel();
        int px;
        int py;
        int frame;
        int expIdx;
        int expAddr;
        bit expHit;
        px      = int'(pixel.x);
        py      = int'(pixel.y);
        expHit  = 0;
        expIdx  = 0;
        expAddr = 0;
        for (int k = 0; k < `NUM_ENEMIES; k++) begin
            if (!expHit && alive[k] && px >= mx[k] && px < mx[k] + `ENEMY_W
                    && py >= my[k] && py < my[k] + `ENEMY_H) begin
                expHit = 1;   // Lowest index wins
                expIdx = k;
                frame  = 3 * int'(mDir[k]);
                if (mStep[k] % 2 == 1) begin
                    frame = frame + 1 + mStep[k] / 2;
                end
                expAddr = (px - mx[k]) + (py - my[k]) * `ENEMY_W + frame * `ENEMY_W * `ENEMY_H;
            end
        end
        compare(3, $sformatf("pixelHit at (%0d,%0d)", px, py), expHit, pixelHit);
        compare(3, $sformatf("hitIndex at (%0d,%0d)", px, py), expIdx, hitIndex);
        compare(3, $sformatf("spriteAddr at (%0d,%0d)", px, py), expAddr, spriteAddr);
    endtask

    always @(posedge Clk) begin
        int t;
        if (resetCheck) begin
            for (int k = 0; k < `NUM_ENEMIES; k++) begin
                mx[k]      = (k + 1) * `X_ORIGIN_STEP - `ENEMY_W / 2;
                my[k]      = (k + 1) * `Y_ORIGIN_STEP - `ENEMY_H / 2;
                mDir[k]    = DIR_DOWN;
                mStep[k]   = 0;
                mAttack[k] = 0;
                compare(0, $sformatf("enemy %0d x", k), mx[k], enemyPos[k].x);
                compare(0, $sformatf("enemy %0d y", k), my[k], enemyPos[k].y);
                compare(0, $sformatf("enemy %0d attackReady", k), 0, attackReady[k]);
            end
            $display("%s: %0d checks, %0d errors", testName[0], testChecks[0], testErrors[0]);
        end
        if (posCheck) begin
            for (int k = 0; k < `NUM_ENEMIES; k++) begin
                if (!alive[k]) begin
                    mAttack[k] = 0;
                end else if (groupDone) begin
                    stepModel(k);
                end
                t = !alive[k] ? 2 : (groupDone ? 1 : 4);
                compare(t, $sformatf("enemy %0d x", k), mx[k], enemyPos[k].x);
                compare(t, $sformatf("enemy %0d y", k), my[k], enemyPos[k].y);
                compare(2, $sformatf("enemy %0d attackReady", k), mAttack[k], attackReady[k]);
            end
        end
        if (pixelCheck) begin
            checkPixel();
        end
        if (report) begin
            for (int i = 1; i < numTests; i++) begin
                $display("%s: %0d checks, %0d errors", testName[i], testChecks[i], testErrors[i]);
            end
        end
    end

endmodule

/* tb/enemy_field_props.sv */
// Concurrent assertions bound into the enemy field top to watch the tick, hit coverage and idle address
`timescale 1ns/1ns
`include "enemy_consts.svh"

module enemy_field_props import enemy_pkg::*; (
    input  logic                    Clk,
    input  logic                    arstN,
    input  logic                    moveTick,
    input  logic [`NUM_ENEMIES-1:0] alive,
    input  posT                     pixel,
    input  posT  [`NUM_ENEMIES-1:0] enemyPos,
    input  logic                    pixelHit,
    input  spriteAddrT              spriteAddr
);

    logic covered;   // Some living enemy box holds the pixel

    always_comb begin
        covered = 1'b0;
        for (int k = 0; k < `NUM_ENEMIES; k++) begin
            if (alive[k] && int'(pixel.x) >= int'(enemyPos[k].x)
                    && int'(pixel.x) < int'(enemyPos[k].x) + `ENEMY_W
                    && int'(pixel.y) >= int'(enemyPos[k].y)
                    && int'(pixel.y) < int'(enemyPos[k].y) + `ENEMY_H) begin
                covered = 1'b1;
            end
        end
    end

    tickOneCycle: assert property (@(posedge Clk) disable iff (!arstN) moveTick |=> !moveTick)
        else $error("moveTick stayed high for more than one cycle");

    hitCovered: assert property (@(posedge Clk) disable iff (!arstN) pixelHit |-> covered)
        else $error("pixelHit is set but no living enemy covers the pixel");

    addrIdle: assert property (@(posedge Clk) disable iff (!arstN) !covered |-> spriteAddr == '0)
        else $error("spriteAddr is not zero without a hit");

endmodule

bind enemy_field enemy_field_props uProps (
    .Clk        (Clk),
    .arstN      (arstN),
    .moveTick   (moveTick),
    .alive      (alive),
    .pixel      (pixel),
    .enemyPos   (enemyPos),
    .pixelHit   (pixelHit),
    .spriteAddr (spriteAddr)
);

/* tb/tb_enemy_field.sv */
// Testbench top for the enemy field with clock, reset, LFSR stimulus, the checker and the summary
`timescale 1ns/1ns
`include "enemy_consts.svh"

module tb_enemy_field import enemy_pkg::*; ();

    localparam int resetCycles   = 10;
    localparam int numFrames     = 64 * `TICK_DIV;
    localparam int frameCycles   = 32;   // 16 high, 16 low
    localparam int timeoutCycles = (numFrames * frameCycles + resetCycles) * 5 / 4;

    logic                    Clk;
    logic                    arstN;
    logic                    frameClk;
    logic [`NUM_ENEMIES-1:0] alive;
    posT                     playerPos;
    posT                     pixel;
    posT  [`NUM_ENEMIES-1:0] enemyPos;
    logic [`NUM_ENEMIES-1:0] attackReady;
    logic                    pixelHit;
    spriteAddrT              spriteAddr;
    logic [1:0]              hitIndex;

    logic        resetCheck;
    logic        posCheck;
    logic        groupDone;
    logic        pixelCheck;
    logic        report;
    int          checks;
    int          errors;
    logic [31:0] lfsrState;
    int          cycles;

    enemy_field i_dut (.*);

    enemy_checker uChecker (.*);

    always #10 Clk = ~Clk;

    always @(posedge Clk) begin
        cycles <= cycles + 1;
        if (cycles >= timeoutCycles) begin
            $display("Timeout: the run did not finish within %0d cycles", timeoutCycles);
            $display("Test failures found");
            $finish;
        end
    end

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic drawBits(input int n, output int value);
        value = 0;
        for (int i = 0; i < n; i++) begin
            lfsrState = lfsrNext(lfsrState);
            value = (value << 1) | int'(lfsrState[0]);
        end
    endtask

    function automatic int clamp(input int v, input int lo, input int hi);
        return (v < lo) ? lo : ((v > hi) ? hi : v);
    endfunction

    // Mostly a one-pixel walk, now and then a jump, the player may roam above the top border
    task automatic movePlayer();
        int r;
        int nx;
        int ny;
        drawBits(4, r);
        drawBits(9, nx);
        drawBits(8, ny);
        if (r != 0) begin
            nx = int'(playerPos.x) + nx % 3 - 1;
            ny = int'(playerPos.y) + ny % 3 - 1;
        end
        playerPos.x = coordT'(clamp(nx, `X_MIN, `X_MAX - `PLAYER_W));
        playerPos.y = coordT'(clamp(ny, 0, `Y_MAX - `PLAYER_H));
    endtask

    initial begin
        int r;
        int k;
        Clk        = 1'b0;
        arstN      = 1'b0;
        frameClk   = 1'b0;
        alive      = '1;
        playerPos  = '{x: 9'd60, y: 9'd0};   // Above enemy 0, which starts beyond the top stop
        pixel      = '0;
        resetCheck = 1'b0;
        posCheck   = 1'b0;
        groupDone  = 1'b0;
        pixelCheck = 1'b0;
        report     = 1'b0;
        lfsrState  = 32'hacd7_2e5f;
        cycles     = 0;
        repeat (resetCycles) @(negedge Clk);
        arstN      = 1'b1;
        resetCheck = 1'b1;
        @(negedge Clk);
        resetCheck = 1'b0;

        for (int f = 1; f <= numFrames; f++) begin
            frameClk = 1'b1;
            repeat (10) @(negedge Clk);   // A move tick has landed by now
            posCheck  = 1'b1;
            groupDone = (f % `TICK_DIV == 0);
            @(negedge Clk);
            posCheck = 1'b0;
            movePlayer();
            drawBits(3, r);
            if (groupDone && r == 0) begin
                drawBits(`NUM_ENEMIES, r);
                alive = r[`NUM_ENEMIES-1:0];   // New dead/alive pattern for the next group
            end
            groupDone = 1'b0;
            repeat (5) @(negedge Clk);
            frameClk = 1'b0;
            for (int p = 0; p < 8; p++) begin
                drawBits(2, k);
                drawBits(5, r);
                pixel.x = enemyPos[k % `NUM_ENEMIES].x + coordT'(r) - 9'd3;
                drawBits(5, r);
                pixel.y = enemyPos[k % `NUM_ENEMIES].y + coordT'(r) - 9'd3;
                pixelCheck = 1'b1;
                @(negedge Clk);
            end
            pixelCheck = 1'b0;
            repeat (8) @(negedge Clk);
        end

        report = 1'b1;
        @(negedge Clk);
        report = 1'b0;
        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

/* sources.f */
+incdir+src
src/enemy_pkg.sv
src/frame_tick.sv
src/walk_anim.sv
src/enemy.sv
src/enemy_field.sv
tb/enemy_checker.sv
tb/enemy_field_props.sv
tb/tb_enemy_field.sv

/* Bender.yml */
package:
  name: enemy_field

export_include_dirs:
  - src

sources:
  - files:
      - src/enemy_pkg.sv
      - src/frame_tick.sv
      - src/walk_anim.sv
      - src/enemy.sv
      - src/enemy_field.sv
  - target: test
    files:
      - tb/enemy_checker.sv
      - tb/enemy_field_props.sv
      - tb/tb_enemy_field.sv
